/* source/disc_pkg.sv */
// shared widths, types and channel counts for the sample discriminator
// referenced by scoped name from every design file

package disc_pkg;

  ////////////////////////////////////////
  // channel geometry
  ////////////////////////////////////////

  // capture channels, each with its own analog trigger
  localparam int CHANNELS = 2;
  // samples delivered per channel on every adc_clk
  localparam int PARALLEL_SAMPLES = 2;
  localparam int SAMPLE_WIDTH = 16;
  localparam int DATA_WIDTH = PARALLEL_SAMPLES * SAMPLE_WIDTH;

  ////////////////////////////////////////
  // delays and timestamps
  ////////////////////////////////////////

  // start and stop delays are counted in adc_clk cycles
  localparam int MAX_DELAY_CYCLES = 16;
  localparam int DELAY_WIDTH = 4;
  // start plus stop, one bit wider than a single delay
  localparam int TOTAL_DELAY_WIDTH = 5;
  // flag register plus start/stop register ahead of the FSM
  localparam int DISC_LATENCY = 2;
  localparam int CLOCK_WIDTH = 32;
  localparam int SAMPLE_INDEX_WIDTH = 16;

  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
  typedef logic [DATA_WIDTH-1:0] channel_data_t;
  typedef logic [DELAY_WIDTH-1:0] delay_t;
  typedef logic [TOTAL_DELAY_WIDTH-1:0] total_delay_t;
  // time in the upper bits, saved-sample index in the lower bits
  typedef logic [CLOCK_WIDTH+SAMPLE_INDEX_WIDTH-1:0] timestamp_t;

  // capture channel state, PRECAPTURE masks stale stop flags
  typedef enum logic [1:0] {
    DISABLED,
    PRECAPTURE,
    CAPTURE
  } capture_state_t;

endpackage

/* source/disc_config_regs.sv */
// live configuration registers, loaded by a one-cycle config_load strobe
// also precomputes the data pipeline tap and the start plus stop delay
`timescale 1ns/10ps

module disc_config_regs (
  input  logic adc_clk,
  input  logic adc_reset,
  input  logic config_load,
  input  disc_pkg::sample_t [disc_pkg::CHANNELS-1:0] threshold_high_in,
  input  disc_pkg::sample_t [disc_pkg::CHANNELS-1:0] threshold_low_in,
  input  disc_pkg::delay_t [disc_pkg::CHANNELS-1:0] start_delay,
  input  disc_pkg::delay_t [disc_pkg::CHANNELS-1:0] stop_delay,
  input  logic [disc_pkg::CHANNELS-1:0] bypass_in,
  output disc_pkg::sample_t [disc_pkg::CHANNELS-1:0] threshold_high,
  output disc_pkg::sample_t [disc_pkg::CHANNELS-1:0] threshold_low,
  output disc_pkg::total_delay_t [disc_pkg::CHANNELS-1:0] pipe_tap,
  output disc_pkg::total_delay_t [disc_pkg::CHANNELS-1:0] total_delay,
  output logic [disc_pkg::CHANNELS-1:0] bypass
);

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      threshold_high <= '0;
      threshold_low <= '0;
      pipe_tap <= '0;
      total_delay <= '0;
      bypass <= '0;
    end else if (config_load) begin
      threshold_high <= threshold_high_in;
      threshold_low <= threshold_low_in;
      bypass <= bypass_in;
      for (int ch = 0; ch < disc_pkg::CHANNELS; ch++) begin
        // data tap covers start delay and the flag/start register latency
        pipe_tap[ch] <= disc_pkg::total_delay_t'(start_delay[ch])
                        + disc_pkg::total_delay_t'(disc_pkg::DISC_LATENCY);
        // stop flags travel through start and stop delay together
        total_delay[ch] <= disc_pkg::total_delay_t'(start_delay[ch])
                           + disc_pkg::total_delay_t'(stop_delay[ch]);
      end
    end
  end

endmodule

/* source/threshold_detector.sv */
// amplitude event detector, one pair of hysteresis flags per channel
// flags are registered one cycle after the sample they describe
`timescale 1ns/10ps

module threshold_detector (
  input  logic adc_clk,
  input  disc_pkg::channel_data_t [disc_pkg::CHANNELS-1:0] data_in,
  input  logic [disc_pkg::CHANNELS-1:0] valid_in,
  input  logic reset_state,
  input  disc_pkg::sample_t [disc_pkg::CHANNELS-1:0] threshold_high,
  input  disc_pkg::sample_t [disc_pkg::CHANNELS-1:0] threshold_low,
  output logic [disc_pkg::CHANNELS-1:0] above_high,
  output logic [disc_pkg::CHANNELS-1:0] below_low
);

  // unregistered compare results
  logic [disc_pkg::CHANNELS-1:0] any_high;
  logic [disc_pkg::CHANNELS-1:0] all_low;

  always_comb begin
    any_high = '0;
    all_low = '1;
    for (int ch = 0; ch < disc_pkg::CHANNELS; ch++) begin
      for (int s = 0; s < disc_pkg::PARALLEL_SAMPLES; s++) begin
        // signed compare of each parallel sample
        if (disc_pkg::sample_t'(data_in[ch][s*disc_pkg::SAMPLE_WIDTH +: disc_pkg::SAMPLE_WIDTH])
            > disc_pkg::sample_t'(threshold_high[ch])) begin
          any_high[ch] = 1'b1;
        end
        // one sample above low keeps the capture alive
        if (disc_pkg::sample_t'(data_in[ch][s*disc_pkg::SAMPLE_WIDTH +: disc_pkg::SAMPLE_WIDTH])
            > disc_pkg::sample_t'(threshold_low[ch])) begin
          all_low[ch] = 1'b0;
        end
      end
    end
  end

  // flags only count for valid words, reset_state forces them low
  always_ff @(posedge adc_clk) begin
    for (int ch = 0; ch < disc_pkg::CHANNELS; ch++) begin
      above_high[ch] <= any_high[ch] && valid_in[ch] && !reset_state;
      below_low[ch] <= all_low[ch] && valid_in[ch] && !reset_state;
    end
  end

endmodule

/* source/sample_delay_line.sv */
// data/valid shift pipeline with a per-channel output tap
// gives the pre-trigger history that a capture starts with
`timescale 1ns/10ps

module sample_delay_line #(
  parameter int DEPTH = disc_pkg::MAX_DELAY_CYCLES + disc_pkg::DISC_LATENCY
) (
  input  logic adc_clk,
  input  disc_pkg::channel_data_t [disc_pkg::CHANNELS-1:0] data_in,
  input  logic [disc_pkg::CHANNELS-1:0] valid_in,
  input  disc_pkg::total_delay_t [disc_pkg::CHANNELS-1:0] pipe_tap,
  input  logic [disc_pkg::CHANNELS-1:0] active,
  output disc_pkg::channel_data_t [disc_pkg::CHANNELS-1:0] data_out,
  output logic [disc_pkg::CHANNELS-1:0] valid_out
);

  // stage 0 holds the previous cycle's input
  disc_pkg::channel_data_t [DEPTH-1:0][disc_pkg::CHANNELS-1:0] data_pipe;
  logic [DEPTH-1:0][disc_pkg::CHANNELS-1:0] valid_pipe;

  always_ff @(posedge adc_clk) begin
    data_pipe <= {data_pipe[DEPTH-2:0], data_in};
    valid_pipe <= {valid_pipe[DEPTH-2:0], valid_in};
  end

  ////////////////////////////////////////
  // tap select and valid gating
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    for (int ch = 0; ch < disc_pkg::CHANNELS; ch++) begin
      data_out[ch] <= data_pipe[pipe_tap[ch]][ch];
      // only samples inside a capture window, or bypassed ones, leave valid
      valid_out[ch] <= valid_pipe[pipe_tap[ch]][ch] && active[ch];
    end
  end

endmodule

/* source/pulse_delay.sv */
// retriggerable delay, one output pulse delay cycles after the latest input pulse
// a new input pulse restarts the countdown
`timescale 1ns/10ps

module pulse_delay (
  input  logic adc_clk,
  input  logic clear,
  input  disc_pkg::total_delay_t delay,
  input  logic in_pls,
  output logic out_pls
);

  // countdown runs only while armed
  logic armed;
  disc_pkg::total_delay_t count;

  // expiry in the same cycle as a retrigger is dropped, the newer pulse wins
  assign out_pls = armed && (count == '0) && !in_pls;

  always_ff @(posedge adc_clk) begin
    if (clear) begin
      armed <= 1'b0;
      count <= '0;
    end else if (in_pls) begin
      armed <= 1'b1;
      // out_pls lands delay cycles after in_pls, delay of at least 1
      count <= delay - disc_pkg::total_delay_t'(1);
    end else if (armed) begin
      if (count == '0) begin
        armed <= 1'b0;
      end else begin
        count <= count - disc_pkg::total_delay_t'(1);
      end
    end
  end

endmodule

/* source/capture_fsm.sv */
// per-channel capture state machine driving the active level
// start is delayed by pulse_delay, stop by a shift pipeline of total_delay
`timescale 1ns/10ps

module capture_fsm (
  input  logic adc_clk,
  input  logic adc_reset,
  input  logic reset_state,
  input  logic [disc_pkg::CHANNELS-1:0] above_high,
  input  logic [disc_pkg::CHANNELS-1:0] below_low,
  input  disc_pkg::total_delay_t [disc_pkg::CHANNELS-1:0] total_delay,
  input  logic [disc_pkg::CHANNELS-1:0] bypass,
  output logic [disc_pkg::CHANNELS-1:0] active
);

  // registered start/stop, second stage of the detector latency
  logic [disc_pkg::CHANNELS-1:0] start;
  logic [disc_pkg::CHANNELS-1:0] stop;
  logic [disc_pkg::CHANNELS-1:0] start_d;
  logic [disc_pkg::CHANNELS-1:0] stop_d;
  // one stage per possible total_delay value
  logic [disc_pkg::CHANNELS-1:0][2**disc_pkg::TOTAL_DELAY_WIDTH-1:0] stop_pipe;
  disc_pkg::capture_state_t state [disc_pkg::CHANNELS];

  ////////////////////////////////////////
  // start and stop conditioning
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (adc_reset || reset_state) begin
      start <= '0;
      stop <= '0;
      stop_pipe <= '0;
    end else begin
      start <= above_high;
      stop <= below_low;
      for (int ch = 0; ch < disc_pkg::CHANNELS; ch++) begin
        stop_pipe[ch] <= {stop_pipe[ch][2**disc_pkg::TOTAL_DELAY_WIDTH-2:0], stop[ch]};
      end
    end
  end

  // stop_d is stop from total_delay+1 cycles back
  // lines the stop up with the start_delay lag of the data pipeline
  always_comb begin
    for (int ch = 0; ch < disc_pkg::CHANNELS; ch++) begin
      stop_d[ch] = stop_pipe[ch][total_delay[ch]];
    end
  end

  // start_d holds off CAPTURE until stale stops have left the pipe
  // start pulses are never lost in a burst
  for (genvar ch = 0; ch < disc_pkg::CHANNELS; ch++) begin : g_start_delay
    pulse_delay u_start_delay (
      .adc_clk(adc_clk),
      .clear(adc_reset || reset_state),
      .delay(total_delay[ch]),
      .in_pls(start[ch]),
      .out_pls(start_d[ch])
    );
  end

  ////////////////////////////////////////
  // state transitions
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (adc_reset || reset_state) begin
      for (int ch = 0; ch < disc_pkg::CHANNELS; ch++) begin
        state[ch] <= disc_pkg::DISABLED;
      end
    end else begin
      for (int ch = 0; ch < disc_pkg::CHANNELS; ch++) begin
        case (state[ch])
          disc_pkg::DISABLED: begin
            if (start[ch]) begin
              // no delay programmed, nothing stale to mask
              state[ch] <= (|total_delay[ch]) ? disc_pkg::PRECAPTURE : disc_pkg::CAPTURE;
            end
          end
          disc_pkg::PRECAPTURE: begin
            // stop flags are ignored here
            if (start_d[ch]) begin
              state[ch] <= disc_pkg::CAPTURE;
            end
          end
          disc_pkg::CAPTURE: begin
            if (start[ch]) begin
              // retrigger, restart the masking window
              if (|total_delay[ch]) begin
                state[ch] <= disc_pkg::PRECAPTURE;
              end
            end else if (|total_delay[ch]) begin
              if (stop_d[ch]) begin
                state[ch] <= disc_pkg::DISABLED;
              end
            end else if (stop[ch]) begin
              state[ch] <= disc_pkg::DISABLED;
            end
          end
          default: begin
            state[ch] <= disc_pkg::DISABLED;
          end
        endcase
      end
    end
  end

  // bypass forces the channel open
  always_comb begin
    for (int ch = 0; ch < disc_pkg::CHANNELS; ch++) begin
      active[ch] = (state[ch] != disc_pkg::DISABLED) || bypass[ch];
    end
  end

endmodule

/* source/timestamp_gen.sv */
// capture timestamps, time of arrival plus number of samples already saved
// one timestamp_valid strobe per rising edge of a channel's active level
`timescale 1ns/10ps

module timestamp_gen (
  input  logic adc_clk,
  input  logic adc_reset,
  input  logic reset_state,
  input  logic [disc_pkg::CHANNELS-1:0] active,
  input  logic [disc_pkg::CHANNELS-1:0] valid_out,
  output disc_pkg::timestamp_t [disc_pkg::CHANNELS-1:0] timestamp,
  output logic [disc_pkg::CHANNELS-1:0] timestamp_valid
);

  // free-running, shared by all channels
  logic [disc_pkg::CLOCK_WIDTH-1:0] clock_count;
  // saved samples per channel since the last reset_state
  logic [disc_pkg::CHANNELS-1:0][disc_pkg::SAMPLE_INDEX_WIDTH-1:0] sample_index;
  logic [disc_pkg::CHANNELS-1:0] active_d;
  logic [disc_pkg::CHANNELS-1:0] start_seen;

  ////////////////////////////////////////
  // counters and edge detect
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      clock_count <= '0;
      sample_index <= '0;
      active_d <= '0;
      start_seen <= '0;
      timestamp_valid <= '0;
    end else begin
      clock_count <= clock_count + 1'b1;
      if (reset_state) begin
        sample_index <= '0;
      end else begin
        for (int ch = 0; ch < disc_pkg::CHANNELS; ch++) begin
          if (valid_out[ch]) begin
            sample_index[ch] <= sample_index[ch] + 1'b1;
          end
        end
      end
      active_d <= active;
      // rising edge of active marks a new capture
      start_seen <= active & ~active_d;
      timestamp_valid <= start_seen;
    end
  end

  // index here excludes the capture's first saved sample
  always_ff @(posedge adc_clk) begin
    for (int ch = 0; ch < disc_pkg::CHANNELS; ch++) begin
      timestamp[ch] <= {clock_count, sample_index[ch]};
    end
  end

endmodule

/* source/sample_discriminator.sv */
// multi-channel ADC sample discriminator top level
// passes only samples around amplitude events, with per-capture timestamps
`timescale 1ns/10ps

module sample_discriminator (
  input  logic adc_clk,
  input  logic adc_reset,
  // realtime clear of hysteresis, capture state and sample index
  input  logic reset_state,
  // configuration, taken on a one-cycle config_load
  input  logic config_load,
  input  disc_pkg::sample_t [disc_pkg::CHANNELS-1:0] threshold_high_in,
  input  disc_pkg::sample_t [disc_pkg::CHANNELS-1:0] threshold_low_in,
  input  disc_pkg::delay_t [disc_pkg::CHANNELS-1:0] start_delay,
  input  disc_pkg::delay_t [disc_pkg::CHANNELS-1:0] stop_delay,
  input  logic [disc_pkg::CHANNELS-1:0] bypass_in,
  // sample stream, valid may have gaps
  input  disc_pkg::channel_data_t [disc_pkg::CHANNELS-1:0] data_in,
  input  logic [disc_pkg::CHANNELS-1:0] valid_in,
  // filtered stream
  output disc_pkg::channel_data_t [disc_pkg::CHANNELS-1:0] data_out,
  output logic [disc_pkg::CHANNELS-1:0] valid_out,
  output disc_pkg::timestamp_t [disc_pkg::CHANNELS-1:0] timestamp,
  output logic [disc_pkg::CHANNELS-1:0] timestamp_valid
);

  // live configuration
  disc_pkg::sample_t [disc_pkg::CHANNELS-1:0] threshold_high;
  disc_pkg::sample_t [disc_pkg::CHANNELS-1:0] threshold_low;
  disc_pkg::total_delay_t [disc_pkg::CHANNELS-1:0] pipe_tap;
  disc_pkg::total_delay_t [disc_pkg::CHANNELS-1:0] total_delay;
  logic [disc_pkg::CHANNELS-1:0] bypass;
  // detector flags and capture window
  logic [disc_pkg::CHANNELS-1:0] above_high;
  logic [disc_pkg::CHANNELS-1:0] below_low;
  logic [disc_pkg::CHANNELS-1:0] active;

  ////////////////////////////////////////
  // configuration
  ////////////////////////////////////////

  disc_config_regs u_config (
    .adc_clk(adc_clk),
    .adc_reset(adc_reset),
    .config_load(config_load),
    .threshold_high_in(threshold_high_in),
    .threshold_low_in(threshold_low_in),
    .start_delay(start_delay),
    .stop_delay(stop_delay),
    .bypass_in(bypass_in),
    .threshold_high(threshold_high),
    .threshold_low(threshold_low),
    .pipe_tap(pipe_tap),
    .total_delay(total_delay),
    .bypass(bypass)
  );

  ////////////////////////////////////////
  // event detection and capture control
  ////////////////////////////////////////

  threshold_detector u_detector (
    .adc_clk(adc_clk),
    .data_in(data_in),
    .valid_in(valid_in),
    .reset_state(reset_state),
    .threshold_high(threshold_high),
    .threshold_low(threshold_low),
    .above_high(above_high),
    .below_low(below_low)
  );

  capture_fsm u_fsm (
    .adc_clk(adc_clk),
    .adc_reset(adc_reset),
    .reset_state(reset_state),
    .above_high(above_high),
    .below_low(below_low),
    .total_delay(total_delay),
    .bypass(bypass),
    .active(active)
  );

  ////////////////////////////////////////
  // datapath and timestamps
  ////////////////////////////////////////

  // data lags the flags by DISC_LATENCY so pre-trigger samples survive
  sample_delay_line u_delay_line (
    .adc_clk(adc_clk),
    .data_in(data_in),
    .valid_in(valid_in),
    .pipe_tap(pipe_tap),
    .active(active),
    .data_out(data_out),
    .valid_out(valid_out)
  );

  timestamp_gen u_timestamp (
    .adc_clk(adc_clk),
    .adc_reset(adc_reset),
    .reset_state(reset_state),
    .active(active),
    .valid_out(valid_out),
    .timestamp(timestamp),
    .timestamp_valid(timestamp_valid)
  );

endmodule

/* test/tb_sample_discriminator.sv */
// directed testbench for the sample discriminator
// drives tagged sample words and checks captures, bypass and timestamps
`timescale 1ns/10ps

module tb_sample_discriminator;

  localparam int CLK_HALF_NS = 5;
  localparam int RESET_CYCLES = 10;
  localparam int TEST_COUNT = 6;
  localparam int CYCLES_PER_TEST = 250;
  // twice the summed test length, in ns
  localparam int WATCHDOG_NS = 2 * (RESET_CYCLES + TEST_COUNT * CYCLES_PER_TEST) * 2 * CLK_HALF_NS;
  localparam disc_pkg::sample_t HIGH_LEVEL = 16'sd20000;
  localparam disc_pkg::sample_t LOW_LEVEL = 16'sd10000;
  // amplitudes for the high sample of each word
  localparam disc_pkg::sample_t EVENT_AMP = 16'sd25000;
  localparam disc_pkg::sample_t MID_AMP = 16'sd15000;
  localparam disc_pkg::sample_t LOW_AMP = 16'sd1000;

  logic adc_clk;
  logic adc_reset;
  logic reset_state;
  logic config_load;
  disc_pkg::sample_t [disc_pkg::CHANNELS-1:0] threshold_high_in;
  disc_pkg::sample_t [disc_pkg::CHANNELS-1:0] threshold_low_in;
  disc_pkg::delay_t [disc_pkg::CHANNELS-1:0] start_delay;
  disc_pkg::delay_t [disc_pkg::CHANNELS-1:0] stop_delay;
  logic [disc_pkg::CHANNELS-1:0] bypass_in;
  disc_pkg::channel_data_t [disc_pkg::CHANNELS-1:0] data_in;
  logic [disc_pkg::CHANNELS-1:0] valid_in;
  disc_pkg::channel_data_t [disc_pkg::CHANNELS-1:0] data_out;
  logic [disc_pkg::CHANNELS-1:0] valid_out;
  disc_pkg::timestamp_t [disc_pkg::CHANNELS-1:0] timestamp;
  logic [disc_pkg::CHANNELS-1:0] timestamp_valid;

  // bookkeeping
  int seq;
  int last_tag;
  int checks;
  int errors;
  int err_base;
  int tests_run;
  logic [31:0] rng;
  // monitor results per channel
  int out_tags [disc_pkg::CHANNELS][$];
  int exp_tags [disc_pkg::CHANNELS][$];
  int ts_time [disc_pkg::CHANNELS][$];
  int ts_index [disc_pkg::CHANNELS][$];
  int total_saved [disc_pkg::CHANNELS];

  sample_discriminator u_dut (
    .adc_clk(adc_clk),
    .adc_reset(adc_reset),
    .reset_state(reset_state),
    .config_load(config_load),
    .threshold_high_in(threshold_high_in),
    .threshold_low_in(threshold_low_in),
    .start_delay(start_delay),
    .stop_delay(stop_delay),
    .bypass_in(bypass_in),
    .data_in(data_in),
    .valid_in(valid_in),
    .data_out(data_out),
    .valid_out(valid_out),
    .timestamp(timestamp),
    .timestamp_valid(timestamp_valid)
  );

  initial adc_clk = 1'b0;
  always #(CLK_HALF_NS) adc_clk = ~adc_clk;

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic compare_values(input string what, input int actual, input int expected);
    checks++;
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s, got %0d, expected %0d", $time, what, actual, expected);
      errors++;
    end
  endtask

  // low sample carries the sequence tag, high sample the amplitude
  task automatic drive_word(input logic [1:0] valid, input disc_pkg::sample_t amp0,
                            input disc_pkg::sample_t amp1);
    @(posedge adc_clk);
    #1;
    data_in[0] = {amp0, 16'(seq)};
    data_in[1] = {amp1, 16'(seq)};
    valid_in = valid;
    last_tag = seq;
    seq++;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) drive_word(2'b00, MID_AMP, MID_AMP);
  endtask

  task automatic configure(input int sd, input int st, input logic [1:0] byp);
    @(posedge adc_clk);
    #1;
    for (int ch = 0; ch < disc_pkg::CHANNELS; ch++) begin
      threshold_high_in[ch] = HIGH_LEVEL;
      threshold_low_in[ch] = LOW_LEVEL;
      start_delay[ch] = 4'(sd);
      stop_delay[ch] = 4'(st);
    end
    bypass_in = byp;
    config_load = 1'b1;
    @(posedge adc_clk);
    #1;
    config_load = 1'b0;
  endtask

  task automatic pulse_reset_state();
    @(posedge adc_clk);
    #1;
    reset_state = 1'b1;
    @(posedge adc_clk);
    #1;
    reset_state = 1'b0;
  endtask

  task automatic start_test();
    err_base = errors;
    for (int ch = 0; ch < disc_pkg::CHANNELS; ch++) begin
      out_tags[ch].delete();
      exp_tags[ch].delete();
      ts_time[ch].delete();
      ts_index[ch].delete();
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    $display("test %s: %s, %0d errors", name, (errors == err_base) ? "ok" : "failed",
             errors - err_base);
  endtask

  // quiet lead-in, event on channel 0, hysteresis middle, fall below low
  task automatic drive_event(input int hold, input int mid, output int trig, output int below);
    repeat (8) drive_word(2'b11, MID_AMP, MID_AMP);
    for (int i = 0; i < hold; i++) begin
      drive_word(2'b11, EVENT_AMP, MID_AMP);
      if (i == 0) trig = last_tag;
    end
    repeat (mid) drive_word(2'b11, MID_AMP, MID_AMP);
    for (int i = 0; i < 8; i++) begin
      drive_word(2'b11, LOW_AMP, MID_AMP);
      if (i == 0) below = last_tag;
    end
    idle(30);
  endtask

  // capture window with start_delay 4 and stop_delay 3
  task automatic check_capture(input int trig, input int below);
    int n;
    int gaps;
    int diff;
    n = out_tags[0].size();
    compare_values("capture has samples", int'(n > 0), 1);
    if (n > 0) begin
      gaps = 0;
      for (int i = 1; i < n; i++) begin
        if (out_tags[0][i] != out_tags[0][i-1] + 1) gaps++;
      end
      compare_values("first saved tag", out_tags[0][0], trig - 4);
      compare_values("capture gaps", gaps, 0);
      diff = out_tags[0][n-1] - (below + 3);
      compare_values("last saved tag within one", int'(diff >= -1 && diff <= 1), 1);
    end
  endtask

  ////////////////////////////////////////
  // monitor
  ////////////////////////////////////////

  // outputs are sampled mid-cycle, away from the driving edge
  always @(negedge adc_clk) begin
    for (int ch = 0; ch < disc_pkg::CHANNELS; ch++) begin
      if (valid_out[ch]) begin
        out_tags[ch].push_back(int'(data_out[ch][disc_pkg::SAMPLE_WIDTH-1:0]));
        total_saved[ch]++;
      end
      if (timestamp_valid[ch]) begin
        ts_time[ch].push_back(int'(timestamp[ch] >> disc_pkg::SAMPLE_INDEX_WIDTH));
        ts_index[ch].push_back(int'(timestamp[ch][disc_pkg::SAMPLE_INDEX_WIDTH-1:0]));
      end
    end
  end

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic bypass_test();
    logic [1:0] v;
    start_test();
    configure(0, 0, 2'b11);
    idle(25);
    start_test();
    for (int i = 0; i < 40; i++) begin
      rng = lcg_next(rng);
      v = rng[17:16];
      drive_word(v, MID_AMP, MID_AMP);
      for (int ch = 0; ch < disc_pkg::CHANNELS; ch++) begin
        if (v[ch]) exp_tags[ch].push_back(last_tag);
      end
    end
    idle(10);
    for (int ch = 0; ch < disc_pkg::CHANNELS; ch++) begin
      compare_values($sformatf("bypass count ch%0d", ch), out_tags[ch].size(),
                     exp_tags[ch].size());
      for (int i = 0; i < exp_tags[ch].size() && i < out_tags[ch].size(); i++) begin
        compare_values($sformatf("bypass tag ch%0d", ch), out_tags[ch][i], exp_tags[ch][i]);
      end
    end
    configure(4, 3, 2'b00);
    idle(10);
    finish_test("bypass");
  endtask

  task automatic quiet_test();
    start_test();
    repeat (30) drive_word(2'b11, MID_AMP, MID_AMP);
    idle(30);
    for (int ch = 0; ch < disc_pkg::CHANNELS; ch++) begin
      compare_values($sformatf("quiet outputs ch%0d", ch), out_tags[ch].size(), 0);
      compare_values($sformatf("quiet timestamps ch%0d", ch), ts_index[ch].size(), 0);
    end
    finish_test("quiet input");
  endtask

  task automatic pretrigger_test();
    int trig;
    int below;
    start_test();
    drive_event(3, 0, trig, below);
    check_capture(trig, below);
    finish_test("pre-trigger and stop delay");
  endtask

  task automatic hysteresis_test();
    int trig;
    int below;
    start_test();
    drive_event(2, 10, trig, below);
    check_capture(trig, below);
    finish_test("hysteresis");
  endtask

  task automatic timestamp_test();
    int trig;
    int below;
    int base;
    int exp_b;
    start_test();
    pulse_reset_state();
    base = total_saved[0];
    drive_event(2, 0, trig, below);
    exp_b = total_saved[0] - base;
    drive_event(2, 0, trig, below);
    compare_values("timestamps after two captures", ts_index[0].size(), 2);
    if (ts_index[0].size() == 2) begin
      compare_values("first index", ts_index[0][0], 0);
      compare_values("second index", ts_index[0][1], exp_b);
      compare_values("time grows", int'(ts_time[0][1] > ts_time[0][0]), 1);
    end
    // index restarts from zero
    pulse_reset_state();
    drive_event(2, 0, trig, below);
    compare_values("timestamps after third capture", ts_index[0].size(), 3);
    if (ts_index[0].size() == 3) begin
      compare_values("index after reset_state", ts_index[0][2], 0);
    end
    compare_values("channel 1 timestamps", ts_index[1].size(), 0);
    finish_test("timestamps");
  endtask

  task automatic independence_test();
    int trig;
    int below;
    start_test();
    drive_event(3, 0, trig, below);
    compare_values("channel 0 captured", int'(out_tags[0].size() > 0), 1);
    compare_values("channel 1 outputs", out_tags[1].size(), 0);
    compare_values("channel 1 timestamps", ts_index[1].size(), 0);
    finish_test("channel independence");
  endtask

  ////////////////////////////////////////
  // sequence and watchdog
  ////////////////////////////////////////

  initial begin
    adc_reset = 1'b1;
    reset_state = 1'b0;
    config_load = 1'b0;
    threshold_high_in = '0;
    threshold_low_in = '0;
    start_delay = '0;
    stop_delay = '0;
    bypass_in = '0;
    data_in = '0;
    // words stay valid through reset so only the FSM reset holds valid_out low
    valid_in = '1;
    seq = 0;
    last_tag = 0;
    checks = 0;
    errors = 0;
    err_base = 0;
    tests_run = 0;
    rng = 32'd63;
    total_saved[0] = 0;
    total_saved[1] = 0;
    repeat (RESET_CYCLES) @(posedge adc_clk);
    #1;
    adc_reset = 1'b0;
    compare_values("valid_out after reset", int'(valid_out), 0);
    compare_values("timestamp_valid after reset", int'(timestamp_valid), 0);
    valid_in = '0;
    idle(20);
    bypass_test();
    quiet_test();
    pretrigger_test();
    hysteresis_test();
    timestamp_test();
    independence_test();
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("simulation timed out after %0d ns, tests did not finish", WATCHDOG_NS);
    $display(">>> FAIL");
    $finish;
  end

endmodule

/* compile.f */
source/disc_pkg.sv
source/disc_config_regs.sv
source/threshold_detector.sv
source/sample_delay_line.sv
source/pulse_delay.sv
source/capture_fsm.sv
source/timestamp_gen.sv
source/sample_discriminator.sv
test/tb_sample_discriminator.sv

/* Makefile */
# Verilator build and run of the sample discriminator testbench
TOP = tb_sample_discriminator

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search the log for the pass message"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   list these targets"

test:
	verilator --binary --timing -f compile.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log
